/* src/cam_pkg.sv */
`default_nettype none

package cam_pkg;

  // **********************************************************
  // Pixel and channel widths
  // **********************************************************
  typedef logic [7:0]  byte_t;    // Raw sensor byte
  typedef logic [15:0] rgb565_t;  // R[15:11] G[10:5] B[4:0]
  typedef logic [7:0]  chan8_t;   // Expanded colour channel, also luma

  // **********************************************************
  // Stream structs
  // **********************************************************
  // Sensor style strobes, no handshake
  typedef struct packed {
    logic vsync;  // Frame level
    logic href;   // Line level
    logic clken;  // One cycle per pixel
  } video_ctrl_t;

  typedef struct packed {
    video_ctrl_t ctrl;
    rgb565_t     rgb;   // Assembled high/low byte pair
  } rgb565_pix_t;

  typedef struct packed {
    video_ctrl_t ctrl;
    chan8_t      y;     // Luma
  } gray_pix_t;

  // **********************************************************
  // Luma weights and frame skip
  // **********************************************************
  // BT.601 Y weights scaled by 256, sum is exactly 256
  parameter int unsigned LUMA_COEF_R = 77;
  parameter int unsigned LUMA_COEF_G = 150;
  parameter int unsigned LUMA_COEF_B = 29;
  parameter int unsigned LUMA_SHIFT  = 8;   // Undo the 256 scale

  parameter int unsigned FRAME_SKIP_DEFAULT = 10;  // Sensor settles after config
  parameter int unsigned SKIP_CNT_W         = 4;   // Holds FRAME_SKIP up to 15

endpackage

`default_nettype wire

/* src/cmos_byte_packer.sv */
`default_nettype none

// Sensor byte pairs in, RGB565 pixel strobes out
module cmos_byte_packer #(
  parameter int unsigned FRAME_SKIP = cam_pkg::FRAME_SKIP_DEFAULT
) (
  input  logic                 cmos_pclk_i,
  input  logic                 rst_n_i,
  input  logic                 cmos_vsync_i,  // Frame level from sensor
  input  logic                 cmos_href_i,   // Line level from sensor
  input  cam_pkg::byte_t       cmos_data_i,   // High byte first, then low
  output cam_pkg::rgb565_pix_t pix_o
);

  import cam_pkg::*;

  typedef logic [SKIP_CNT_W-1:0] skip_cnt_t;

  localparam skip_cnt_t SKIP_TARGET = skip_cnt_t'(FRAME_SKIP);

  byte_t     hi_byte_q;    // First byte of the pair
  logic      lo_phase_q;   // Set while the next byte is the low byte
  skip_cnt_t skip_cnt_q;   // vsync rising edges seen since reset
  logic      vsync_rise;
  logic      skip_done;
  logic      pix_strobe;   // Low byte on the bus this cycle

  // **********************************************************
  // Byte phase
  // **********************************************************
  assign pix_strobe = cmos_href_i & lo_phase_q;

  // Phase restarts at high byte outside href, so an odd
  // trailing byte never pairs with the next line
  always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      lo_phase_q <= 1'b0;
    end
    else if (!cmos_href_i)
    begin
      lo_phase_q <= 1'b0;
    end
    else
    begin
      lo_phase_q <= ~lo_phase_q;  // Alternate high / low
    end
  end

  always_ff @(posedge cmos_pclk_i)
  begin
    if (cmos_href_i && !lo_phase_q)
    begin
      hi_byte_q <= cmos_data_i;  // Park high byte until its partner
    end
  end

  // **********************************************************
  // Startup frame skip
  // **********************************************************
  // Registered vsync in pix_o doubles as the edge detector delay
  assign vsync_rise = cmos_vsync_i & ~pix_o.ctrl.vsync;
  assign skip_done  = (skip_cnt_q == SKIP_TARGET);

  always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      skip_cnt_q <= '0;
    end
    else if (vsync_rise && !skip_done)
    begin
      skip_cnt_q <= skip_cnt_q + 1'b1;  // Saturates at target
    end
  end

  // **********************************************************
  // Output register
  // **********************************************************
  always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pix_o <= '0;
    end
    else
    begin
      pix_o.ctrl.vsync <= cmos_vsync_i;             // One cycle delay
      pix_o.ctrl.href  <= cmos_href_i;              // Lines up with clken
      pix_o.ctrl.clken <= pix_strobe & skip_done;   // Gated until skip done
      if (pix_strobe)
      begin
        pix_o.rgb <= {hi_byte_q, cmos_data_i};    // Holds between pixels
      end
    end
  end

  // Two bytes per pixel, so strobes are at least two cycles apart
  a_clken_spaced : assert property (
    @(posedge cmos_pclk_i) disable iff (!rst_n_i)
    pix_o.ctrl.clken |=> !pix_o.ctrl.clken
  ) else $error("cmos_byte_packer: clken high in consecutive cycles");

endmodule

`default_nettype wire

/* src/luma_pipeline.sv */
`default_nettype none

// RGB565 to 8-bit luma, three register stages
module luma_pipeline (
  input  logic                 cmos_pclk_i,
  input  logic                 rst_n_i,
  input  cam_pkg::rgb565_pix_t pix_i,
  output cam_pkg::gray_pix_t   gray_o
);

  import cam_pkg::*;

  localparam int unsigned CHAN_W     = $bits(chan8_t);
  localparam int unsigned PROD_W     = 2 * CHAN_W;  // 8 x 8 bit product
  localparam int unsigned PIPE_DEPTH = 3;

  // Weights sum to 256, so the sum of products fits PROD_W
  typedef logic [PROD_W-1:0] prod_t;

  chan8_t      red8;
  chan8_t      green8;
  chan8_t      blue8;
  prod_t       prod_r_q;
  prod_t       prod_g_q;
  prod_t       prod_b_q;
  prod_t       sum_q;
  chan8_t      y_q;
  video_ctrl_t ctrl_q [PIPE_DEPTH];  // Timing travels with the data

  // **********************************************************
  // Stage one, expand and weight
  // **********************************************************
  // Top bits copied into the low bits, full scale maps to 255
  assign red8   = {pix_i.rgb[15:11], pix_i.rgb[15:13]};
  assign green8 = {pix_i.rgb[10:5], pix_i.rgb[10:9]};
  assign blue8  = {pix_i.rgb[4:0], pix_i.rgb[4:2]};

  always_ff @(posedge cmos_pclk_i)
  begin
    prod_r_q <= prod_t'(red8) * prod_t'(LUMA_COEF_R);
    prod_g_q <= prod_t'(green8) * prod_t'(LUMA_COEF_G);
    prod_b_q <= prod_t'(blue8) * prod_t'(LUMA_COEF_B);
  end

  // **********************************************************
  // Stage two, sum
  // **********************************************************
  always_ff @(posedge cmos_pclk_i)
  begin
    sum_q <= prod_r_q + prod_g_q + prod_b_q;  // Max 255 * 256
  end

  // **********************************************************
  // Stage three, scale and timing delay line
  // **********************************************************
  // Free running, a new pixel may enter every cycle
  always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      y_q <= '0;
      for (int i = 0; i < PIPE_DEPTH; i++)
      begin
        ctrl_q[i] <= '0;
      end
    end
    else
    begin
      y_q       <= sum_q[LUMA_SHIFT +: CHAN_W];  // Divide by 256
      ctrl_q[0] <= pix_i.ctrl;
      for (int i = 1; i < PIPE_DEPTH; i++)
      begin
        ctrl_q[i] <= ctrl_q[i-1];
      end
    end
  end

  assign gray_o = '{ctrl: ctrl_q[PIPE_DEPTH-1], y: y_q};

  // Pixel strobes only ever arrive inside a line
  a_clken_in_line : assert property (
    @(posedge cmos_pclk_i) disable iff (!rst_n_i)
    gray_o.ctrl.clken |-> gray_o.ctrl.href
  ) else $error("luma_pipeline: clken outside href");

endmodule

`default_nettype wire

/* src/cmos_gray_top.sv */
`default_nettype none

// Camera input path, sensor bytes to gray stream
// Latency four cycles from low byte sample to gray_o clken
module cmos_gray_top #(
  parameter int unsigned FRAME_SKIP = cam_pkg::FRAME_SKIP_DEFAULT
) (
  input  logic               cmos_pclk_i,   // Sensor pixel clock, only clock
  input  logic               rst_n_i,
  input  logic               cmos_vsync_i,
  input  logic               cmos_href_i,
  input  cam_pkg::byte_t     cmos_data_i,
  output cam_pkg::gray_pix_t gray_o
);

  import cam_pkg::*;

  // **********************************************************
  // Sensor decode
  // **********************************************************
  rgb565_pix_t packed_pix;  // One cycle behind the sensor

  cmos_byte_packer #(
    .FRAME_SKIP (FRAME_SKIP)
  ) cmos_byte_packer_i (
    .cmos_pclk_i  (cmos_pclk_i),
    .rst_n_i      (rst_n_i),
    .cmos_vsync_i (cmos_vsync_i),
    .cmos_href_i  (cmos_href_i),
    .cmos_data_i  (cmos_data_i),
    .pix_o        (packed_pix)
  );

  // **********************************************************
  // Video image processor
  // **********************************************************
  // Three more cycles, timing and luma stay aligned
  luma_pipeline luma_pipeline_i (
    .cmos_pclk_i (cmos_pclk_i),
    .rst_n_i     (rst_n_i),
    .pix_i       (packed_pix),
    .gray_o      (gray_o)
  );

endmodule

`default_nettype wire

/* verification/tb_cmos_tasks.svh */
`ifndef TB_CMOS_TASKS_SVH
`define TB_CMOS_TASKS_SVH

`default_nettype none

// **********************************************************
// Error handling and checks
// **********************************************************
task automatic fail_and_stop();
  $display("Simulation failed");
  $fatal(1, "stopped at first error");
endtask

task automatic check_equal(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual)
  begin
    $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
    fail_and_stop();
  end
endtask

// **********************************************************
// Reference model and random pixels
// **********************************************************
// Expand each channel by repeating its top bits, then weight 77/150/29 over 256
function automatic chan8_t luma_model(input rgb565_t pix);
  int unsigned r5;
  int unsigned g6;
  int unsigned b5;
  int unsigned r8;
  int unsigned g8;
  int unsigned b8;
  r5 = 32'(pix[15:11]);
  g6 = 32'(pix[10:5]);
  b5 = 32'(pix[4:0]);
  r8 = (r5 << 3) | (r5 >> 2);  // 31 maps to 255
  g8 = (g6 << 2) | (g6 >> 4);  // 63 maps to 255
  b8 = (b5 << 3) | (b5 >> 2);
  return chan8_t'((77 * r8 + 150 * g8 + 29 * b8) >> 8);
endfunction

// Taps 32, 22, 2, 1
function automatic logic lfsr_step();
  logic fb;
  fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic rgb565_t random_pixel();
  rgb565_t pix;
  pix = '0;
  for (int b = 0; b < 16; b++)
  begin
    pix = {pix[14:0], lfsr_step()};  // One step per bit
  end
  return pix;
endfunction

// **********************************************************
// Sensor driving
// **********************************************************
task automatic drive_idle(input int unsigned cycles);
  repeat (cycles)
  begin
    @(negedge cmos_pclk);
    cmos_href = 1'b0;
    cmos_data = '0;
  end
endtask

task automatic send_byte(input byte_t data);
  @(negedge cmos_pclk);
  cmos_href = 1'b1;
  cmos_data = data;
endtask

task automatic pulse_vsync();
  @(negedge cmos_pclk);
  cmos_href  = 1'b0;
  cmos_vsync = 1'b1;  // Rising edge starts a frame
  repeat (3) @(negedge cmos_pclk);
  cmos_vsync = 1'b0;
  drive_idle(4);
endtask

// High byte first, optional stray byte at the end of the line
task automatic send_line(input rgb565_t pixels [$], input bit odd_tail);
  foreach (pixels[i])
  begin
    send_byte(pixels[i][15:8]);
    send_byte(pixels[i][7:0]);
  end
  if (odd_tail)
  begin
    send_byte(8'ha5);  // Has no partner, must vanish
  end
  drive_idle(2);       // href low between lines
endtask

// Waits for the gray pixels, then checks count and every luma
task automatic expect_pixels(input string test_name, input rgb565_t pixels [$]);
  int unsigned waited;
  chan8_t      y;
  waited = 0;
  while (y_queue.size() < pixels.size())
  begin
    drive_idle(1);
    waited++;
    if (waited > WAIT_LIMIT)
    begin
      $display("Timeout in %s: %0d of %0d gray pixels arrived", test_name,
               y_queue.size(), pixels.size());
      fail_and_stop();
    end
  end
  drive_idle(8);  // Longer than the pipeline, stray pulses show up
  check_equal({test_name, " count"}, 32'(pixels.size()), 32'(y_queue.size()));
  foreach (pixels[i])
  begin
    y = y_queue.pop_front();
    check_equal(test_name, 32'(luma_model(pixels[i])), 32'(y));
  end
endtask

// **********************************************************
// Directed tests
// **********************************************************
task automatic reset_state_test();
  repeat (RESET_CYCLES)
  begin
    @(negedge cmos_pclk);
    check_equal("reset held", 32'h0,
                32'({gray.ctrl.vsync, gray.ctrl.href, gray.ctrl.clken}));
  end
  rst_n = 1'b1;  // Released on a falling edge
  repeat (3)
  begin
    @(negedge cmos_pclk);
    check_equal("after reset", 32'h0,
                32'({gray.ctrl.vsync, gray.ctrl.href, gray.ctrl.clken}));
  end
endtask

task automatic frame_skip_test();
  rgb565_t early [$];
  rgb565_t third [$];
  early = '{16'h1234, 16'hbeef, 16'h0f0f};
  third = '{16'h4a69, 16'hd6ba};
  send_line(early, 1'b0);  // Frame one, already running at reset
  pulse_vsync();           // Frame two
  send_line(early, 1'b0);
  drive_idle(8);
  check_equal("frame skip suppressed", 32'h0, 32'(y_queue.size()));
  pulse_vsync();           // Frame three, skip count reached
  send_line(third, 1'b0);
  expect_pixels("frame skip third frame", third);
endtask

task automatic fixed_colour_test();
  rgb565_t colours [$];
  colours = '{16'hffff, 16'h0000, 16'hf800, 16'h07e0, 16'h001f};  // W K R G B
  send_line(colours, 1'b0);
  expect_pixels("fixed colours", colours);
endtask

task automatic random_line_test();
  rgb565_t line [$];
  repeat (64)
  begin
    line.push_back(random_pixel());
  end
  send_line(line, 1'b0);
  expect_pixels("random line", line);
endtask

task automatic odd_byte_test();
  rgb565_t first [$];
  rgb565_t second [$];
  rgb565_t all [$];
  first  = '{16'h8421, 16'h7bde};
  second = '{16'hc3a5, 16'h1e78};
  all    = '{16'h8421, 16'h7bde, 16'hc3a5, 16'h1e78};
  send_line(first, 1'b1);   // Stray byte closes the line
  send_line(second, 1'b0);  // Pairs from its own first byte
  expect_pixels("odd trailing byte", all);
endtask

task automatic latency_test();
  int unsigned edges;
  logic        clken_seen;
  rgb565_t     single [$];
  single = '{16'h5ac3};
  drive_idle(6);    // Pipeline empty
  send_byte(8'h5a);
  send_byte(8'hc3); // Sampled by the next rising edge
  edges      = 0;
  clken_seen = 1'b0;
  while (!clken_seen)
  begin
    drive_idle(1);
    edges++;
    clken_seen = gray.ctrl.clken;
    if (!clken_seen && edges > WAIT_LIMIT)
    begin
      $display("Timeout in latency: gray clken never rose");
      fail_and_stop();
    end
  end
  check_equal("latency cycles", 32'd4, 32'(edges));
  expect_pixels("latency value", single);
endtask

`default_nettype wire

`endif

/* verification/tb_cmos_gray_top.sv */
`default_nettype none

// Testbench for the camera gray path
// Sensor side driven on falling edges, gray stream sampled there too
module tb_cmos_gray_top;

  timeunit 1ns;
  timeprecision 1ps;

  import cam_pkg::*;

  localparam int unsigned FRAME_SKIP   = 2;    // Third frame is the first to pass
  localparam int unsigned CLK_HALF_NS  = 10;   // 20 ns pixel clock
  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned WAIT_LIMIT   = 200;  // Cycles before a wait gives up
  localparam int unsigned LEVEL_DELAY  = 4;    // Sensor levels to gray_o levels

  // **********************************************************
  // DUT signals
  // **********************************************************
  logic      cmos_pclk;
  logic      rst_n;
  logic      cmos_vsync;
  logic      cmos_href;
  byte_t     cmos_data;
  gray_pix_t gray;

  chan8_t      y_queue [$];  // Luma of every gray clken, oldest first
  logic [31:0] lfsr_state;   // Random pixel source
  logic [1:0]  level_hist [LEVEL_DELAY];  // {vsync, href} per rising edge, newest first

  cmos_gray_top #(
    .FRAME_SKIP (FRAME_SKIP)
  ) cmos_gray_top_i (
    .cmos_pclk_i  (cmos_pclk),
    .rst_n_i      (rst_n),
    .cmos_vsync_i (cmos_vsync),
    .cmos_href_i  (cmos_href),
    .cmos_data_i  (cmos_data),
    .gray_o       (gray)
  );

  `include "tb_cmos_tasks.svh"

  // **********************************************************
  // Clock and output monitor
  // **********************************************************
  always #(CLK_HALF_NS) cmos_pclk = ~cmos_pclk;

  // Sensor levels as the DUT samples them
  always @(posedge cmos_pclk)
  begin
    for (int i = LEVEL_DELAY - 1; i > 0; i--)
    begin
      level_hist[i] = level_hist[i-1];
    end
    level_hist[0] = {cmos_vsync, cmos_href};
  end

  // gray changes on rising edges only, stable here
  always @(negedge cmos_pclk)
  begin
    if (rst_n)
    begin
      check_equal("vsync href delay", 32'(level_hist[LEVEL_DELAY-1]),
                  32'({gray.ctrl.vsync, gray.ctrl.href}));
      if (gray.ctrl.clken)
      begin
        y_queue.push_back(gray.y);  // One entry per pixel strobe
      end
    end
  end

  // **********************************************************
  // Test sequence
  // **********************************************************
  initial
  begin
    cmos_pclk  = 1'b0;
    rst_n      = 1'b0;  // Held through reset_state_test
    cmos_vsync = 1'b0;
    cmos_href  = 1'b0;
    cmos_data  = '0;
    lfsr_state = 32'h34f6_c90f;
    for (int i = 0; i < LEVEL_DELAY; i++)
    begin
      level_hist[i] = 2'b00;
    end

    reset_state_test();
    frame_skip_test();    // Must run first after reset
    fixed_colour_test();
    random_line_test();
    odd_byte_test();
    latency_test();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verification
src/cam_pkg.sv
src/cmos_byte_packer.sv
src/luma_pipeline.sv
src/cmos_gray_top.sv
verification/tb_cmos_gray_top.sv

/* Makefile */
# Verilator build and run of the camera gray path testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_cmos_gray_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

# Result is decided by the pass line in the log, not the exit code of the run
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
